// File: design/branch_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
    id_ex_if.sink                   id_ex,
    input  ex_pkg::br_op_e          branch_alu_op,
    input  logic [ex_pkg::xlen-1:0] alu_result,
    ex_mem_if.source                ex_mem
);
    import ex_pkg::*;

    logic            taken;
    logic            is_jump;
    logic [xlen-1:0] link;

    assign is_jump = (branch_alu_op == br_jump);
    // Return address for JAL and JALR
    assign link    = id_ex.pc + xlen'(4);

    // Branch condition on the two register operands
    always_comb begin
        case (branch_alu_op)
            br_eq:   taken = (id_ex.data1 == id_ex.data2);
            br_ne:   taken = (id_ex.data1 != id_ex.data2);
            br_lt:   taken = ($signed(id_ex.data1) < $signed(id_ex.data2));
            br_ge:   taken = ($signed(id_ex.data1) >= $signed(id_ex.data2));
            br_ltu:  taken = (id_ex.data1 < id_ex.data2);
            br_geu:  taken = (id_ex.data1 >= id_ex.data2);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign ex_mem.valid      = id_ex.valid;
    assign ex_mem.redirect   = id_ex.valid && taken;
    assign ex_mem.target     = alu_result;
    assign ex_mem.result     = is_jump ? link : alu_result;
    assign ex_mem.store_data = id_ex.data2;
    assign ex_mem.rd         = id_ex.rd;

endmodule

`default_nettype wire

// File: design/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    id_ex_if.sink                   id_ex,
    input  logic                    a_sel,
    input  logic                    b_sel,
    input  ex_pkg::alu_op_e         alu_op,
    output logic [ex_pkg::xlen-1:0] alu_result
);
    import ex_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] sum;
    logic [4:0]      shamt;

    // Operand muxes
    assign op_a  = a_sel ? id_ex.pc : id_ex.data1;
    assign op_b  = b_sel ? id_ex.imm : id_ex.data2;

    // Shared adder, also feeds the jump and branch targets
    assign sum   = op_a + op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:         alu_result = sum;
            alu_sub:         alu_result = op_a - op_b;
            alu_sll:         alu_result = op_a << shamt;
            alu_slt:         alu_result = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu:        alu_result = xlen'(op_a < op_b);
            alu_xor:         alu_result = op_a ^ op_b;
            alu_srl:         alu_result = op_a >> shamt;
            alu_sra:         alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_or:          alu_result = op_a | op_b;
            alu_and:         alu_result = op_a & op_b;
            // LUI, the immediate already sits in the upper bits
            alu_pass_b:      alu_result = op_b;
            // JALR clears the low target bit
            alu_jalr_target: alu_result = {sum[xlen-1:1], 1'b0};
            default:         alu_result = sum;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ex_ctrl (
    input  logic [ex_pkg::opcode_w-1:0] opcode,
    input  logic [ex_pkg::funct3_w-1:0] funct3,
    input  logic [ex_pkg::funct7_w-1:0] funct7,
    // 0 selects data1, 1 selects pc
    output logic                        a_sel,
    // 0 selects data2, 1 selects imm
    output logic                        b_sel,
    output ex_pkg::br_op_e              branch_alu_op,
    output ex_pkg::alu_op_e             alu_op
);
    import ex_pkg::*;

    // Only AUIPC, JAL and branches start from the pc
    function automatic logic a_sel_dec(input logic [opcode_w-1:0] op);
        logic uses_pc;
        uses_pc = (op == op_auipc) || (op == op_jal) || (op == op_branch);
        return uses_pc;
    endfunction

    // Register-register ops are the only ones reading data2 into the ALU
    function automatic logic b_sel_dec(input logic [opcode_w-1:0] op);
        logic is_reg_reg;
        is_reg_reg = (op == op_op);
        return !is_reg_reg;
    endfunction

    function automatic br_op_e br_op_dec(input logic [opcode_w-1:0] op,
                                         input logic [funct3_w-1:0] f3);
        br_op_e sel;
        if (op == op_jal || op == op_jalr) begin
            sel = br_jump;
        end else if (op == op_branch) begin
            sel = br_op_e'(f3);
        end else begin
            sel = br_none;
        end
        return sel;
    endfunction

    function automatic alu_op_e alu_op_dec(input logic [opcode_w-1:0] op,
                                           input logic [funct3_w-1:0] f3,
                                           input logic [funct7_w-1:0] f7);
        alu_op_e sel;
        logic    is_arith;
        is_arith = (op == op_op) || (op == op_op_imm);
        if (op == op_lui) begin
            sel = alu_pass_b;
        end else if (op == op_jalr) begin
            sel = alu_jalr_target;
        end else if (is_arith) begin
            case (f3)
                // ADDI ignores funct7, its upper immediate bits land there
                3'b000:  sel = (op == op_op) ? alu_op_e'({f7[5], f3}) : alu_add;
                // SRL, SRLI, SRA, SRAI
                3'b101:  sel = alu_op_e'({f7[5], f3});
                default: sel = alu_op_e'({1'b0, f3});
            endcase
        end else begin
            // Loads, stores, AUIPC, JAL, branches and unknown opcodes add
            sel = alu_add;
        end
        return sel;
    endfunction

    assign a_sel         = a_sel_dec(opcode);
    assign b_sel         = b_sel_dec(opcode);
    assign branch_alu_op = br_op_dec(opcode, funct3);
    assign alu_op        = alu_op_dec(opcode, funct3, funct7);

endmodule

`default_nettype wire

// File: design/ex_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded instruction held in the ID/EX register
interface id_ex_if;
    import ex_pkg::*;

    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       data1;
    logic [xlen-1:0]       data2;
    logic [xlen-1:0]       imm;
    logic [opcode_w-1:0]   opcode;
    logic [funct3_w-1:0]   funct3;
    logic [funct7_w-1:0]   funct7;
    logic [reg_addr_w-1:0] rd;

    modport source (output valid, pc, data1, data2, imm, opcode, funct3, funct7, rd);
    modport sink   (input  valid, pc, data1, data2, imm, opcode, funct3, funct7, rd);
endinterface

// Execute results on their way to the EX/MEM register
interface ex_mem_if;
    import ex_pkg::*;

    logic                  valid;
    logic [xlen-1:0]       result;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd;
    logic                  redirect;
    logic [xlen-1:0]       target;

    modport source (output valid, result, store_data, rd, redirect, target);
    modport sink   (input  valid, result, store_data, rd, redirect, target);
endinterface

`default_nettype wire

// File: design/ex_mem_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    ex_mem_if.sink                        ex_mem,
    output logic                          out_valid,
    output logic [ex_pkg::xlen-1:0]       out_result,
    output logic [ex_pkg::xlen-1:0]       out_store_data,
    output logic [ex_pkg::reg_addr_w-1:0] out_rd,
    output logic                          out_redirect,
    output logic [ex_pkg::xlen-1:0]       out_target
);
    import ex_pkg::*;

    // Control bits toward the memory stage
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            out_redirect <= 1'b0;
        end else if (!stall) begin
            out_valid    <= ex_mem.valid;
            out_redirect <= ex_mem.redirect;
        end
    end

    // Result payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_result     <= ex_mem.result;
            out_store_data <= ex_mem.store_data;
            out_rd         <= ex_mem.rd;
            out_target     <= ex_mem.target;
        end
    end

    // Also covers the stall hold, where both bits come from the previous cycle
    out_redirect_valid: assert property (@(posedge clk) disable iff (reset)
                                         out_redirect |-> out_valid)
        else $error("out_redirect without out_valid");

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // Data path and instruction field widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    // RV32I major opcodes
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] op_op     = 7'b0110011;

    // ALU operations
    // Low three bits follow funct3, bit 3 turns ADD into SUB and SRL into SRA
    typedef enum logic [3:0] {
        alu_add         = 4'd0,
        alu_sll         = 4'd1,
        alu_slt         = 4'd2,
        alu_sltu        = 4'd3,
        alu_xor         = 4'd4,
        alu_srl         = 4'd5,
        alu_or          = 4'd6,
        alu_and         = 4'd7,
        alu_sub         = 4'd8,
        alu_pass_b      = 4'd9,
        alu_jalr_target = 4'd10,
        alu_sra         = 4'd13
    } alu_op_e;

    // Branch conditions, conditional codes equal funct3
    typedef enum logic [2:0] {
        br_eq   = 3'd0,
        br_ne   = 3'd1,
        br_jump = 3'd2,
        br_none = 3'd3,
        br_lt   = 3'd4,
        br_ge   = 3'd5,
        br_ltu  = 3'd6,
        br_geu  = 3'd7
    } br_op_e;

endpackage

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic [ex_pkg::xlen-1:0]       pc,
    input  logic [ex_pkg::xlen-1:0]       data1,
    input  logic [ex_pkg::xlen-1:0]       data2,
    input  logic [ex_pkg::xlen-1:0]       imm,
    input  logic [ex_pkg::opcode_w-1:0]   opcode,
    input  logic [ex_pkg::funct3_w-1:0]   funct3,
    input  logic [ex_pkg::funct7_w-1:0]   funct7,
    input  logic [ex_pkg::reg_addr_w-1:0] rd,
    output logic                          out_valid,
    output logic [ex_pkg::xlen-1:0]       out_result,
    output logic [ex_pkg::xlen-1:0]       out_store_data,
    output logic [ex_pkg::reg_addr_w-1:0] out_rd,
    output logic                          out_redirect,
    output logic [ex_pkg::xlen-1:0]       out_target
);
    import ex_pkg::*;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    logic            a_sel;
    logic            b_sel;
    alu_op_e         alu_op;
    br_op_e          branch_alu_op;
    logic [xlen-1:0] alu_result;

    // Input side
    id_ex_reg id_ex_reg_inst (
        .clk, .reset, .stall, .flush, .in_valid,
        .pc, .data1, .data2, .imm, .opcode, .funct3, .funct7, .rd,
        .id_ex (id_ex_bus.source)
    );

    // Execute logic
    ex_ctrl ex_ctrl_inst (
        .opcode (id_ex_bus.opcode),
        .funct3 (id_ex_bus.funct3),
        .funct7 (id_ex_bus.funct7),
        .a_sel, .b_sel, .branch_alu_op, .alu_op
    );

    ex_alu ex_alu_inst (
        .id_ex (id_ex_bus.sink),
        .a_sel, .b_sel, .alu_op, .alu_result
    );

    branch_resolve branch_resolve_inst (
        .id_ex  (id_ex_bus.sink),
        .branch_alu_op, .alu_result,
        .ex_mem (ex_mem_bus.source)
    );

    // Output side
    ex_mem_reg ex_mem_reg_inst (
        .clk, .reset, .stall,
        .ex_mem (ex_mem_bus.sink),
        .out_valid, .out_result, .out_store_data, .out_rd, .out_redirect, .out_target
    );

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic [ex_pkg::xlen-1:0]       pc,
    input  logic [ex_pkg::xlen-1:0]       data1,
    input  logic [ex_pkg::xlen-1:0]       data2,
    input  logic [ex_pkg::xlen-1:0]       imm,
    input  logic [ex_pkg::opcode_w-1:0]   opcode,
    input  logic [ex_pkg::funct3_w-1:0]   funct3,
    input  logic [ex_pkg::funct7_w-1:0]   funct7,
    input  logic [ex_pkg::reg_addr_w-1:0] rd,
    id_ex_if.source                       id_ex
);
    import ex_pkg::*;

    // Valid bit, flush wins over a new instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex.valid <= in_valid && !flush;
        end
    end

    // Instruction fields
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_ex.pc     <= pc;
            id_ex.data1  <= data1;
            id_ex.data2  <= data2;
            id_ex.imm    <= imm;
            id_ex.opcode <= opcode;
            id_ex.funct3 <= funct3;
            id_ex.funct7 <= funct7;
            id_ex.rd     <= rd;
        end
    end

    valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(id_ex.valid))
        else $error("id_ex valid is unknown after reset");

endmodule

`default_nettype wire

// File: dv/ex_stage_tests.svh
task automatic reset_clears_outputs();
    // Reset again while a valid JAL waits at the input
    @(posedge clk);
    reset <= 1'b1;
    drive_instr(1'b1, op_jal, 3'd0, 7'd0, 32'h500, 32'd0, 32'd0, 32'h40, 5'd5);
    repeat (3) @(posedge clk);
    reset    <= 1'b0;
    in_valid <= 1'b0;
    @(negedge clk);
    check_value("out_valid", 32'd0, {31'd0, out_valid});
    check_value("out_redirect", 32'd0, {31'd0, out_redirect});
endtask

// Round 0 shifts by 37 with a negative data1, round 1 has a negative data2
task automatic reg_reg_ops();
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    for (int c = 0; c < 16; c++) begin
        if (c > 8 && c != 13) continue;
        for (int i = 0; i < 12; i++) begin
            a = (i == 0) ? 32'h8000_0000 : $urandom();
            b = (i == 0) ? 32'd37 : (i == 1) ? 32'hffff_fffb : $urandom();
            exec_check(op_op, 3'(c), {1'b0, c[3], 5'd0}, a, b, $urandom());
        end
    end
endtask

task automatic imm_and_upper_ops();
    logic [xlen-1:0] imm_v;
    for (int i = 0; i < 8; i++) begin
        // Bit 10 of the immediate shows up as funct7 bit 5
        imm_v = {{21{i[0]}}, 1'b1, 10'($urandom())};
        exec_check(op_op_imm, 3'd0, imm_v[11:5], $urandom(), $urandom(), imm_v);
        imm_v = {27'd0, 5'($urandom())};
        exec_check(op_op_imm, 3'd5, 7'h00, $urandom(), $urandom(), imm_v);
        exec_check(op_op_imm, 3'd5, 7'h20, $urandom() | 32'h8000_0000, $urandom(),
                   imm_v | 32'h400);
        imm_v = {20'($urandom()), 12'd0};
        exec_check(op_lui, 3'd0, 7'd0, $urandom(), $urandom(), imm_v);
        exec_check(op_auipc, 3'd0, 7'd0, $urandom(), $urandom(), imm_v);
    end
endtask

task automatic branch_conditions();
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    for (int f = 0; f < 8; f++) begin
        if (f == 2 || f == 3) continue;
        for (int j = 0; j < 4; j++) begin
            // Equal, less, negative against positive and the reverse
            a = (j == 2) ? 32'hffff_fff0 : (j == 3) ? 32'd3 : 32'd5;
            b = (j == 0) ? 32'd5 : (j == 1) ? 32'd7 : (j == 2) ? 32'd3 : 32'hffff_fff0;
            exec_check(op_branch, 3'(f), 7'd0, a, b, {{20{j[0]}}, 11'($urandom()), 1'b0});
        end
    end
endtask

task automatic jumps_loads_stores();
    for (int i = 0; i < 6; i++) begin
        exec_check(op_jal, 3'd0, 7'd0, $urandom(), $urandom(),
                   {{12{i[0]}}, 19'($urandom()), 1'b0});
        // Odd data1 and even imm give an odd sum for the target bit clear
        exec_check(op_jalr, 3'd0, 7'd0, $urandom() | 32'h1, $urandom(),
                   {{20{i[1]}}, 11'($urandom()), 1'b0});
        exec_check(op_load, 3'd2, 7'd0, $urandom(), $urandom(), {{20{i[0]}}, 12'($urandom())});
        exec_check(op_store, 3'd2, 7'd0, $urandom(), $urandom(), {{20{i[1]}}, 12'($urandom())});
    end
endtask

task automatic stall_flush_valid();
    logic [3*xlen+reg_addr_w+1:0] snap;
    logic [3*xlen+reg_addr_w+1:0] held;
    // JAL reaches the output, then stall freezes it while a second JAL waits
    @(posedge clk);
    drive_instr(1'b1, op_jal, 3'd0, 7'd0, 32'h100, 32'd0, 32'd0, 32'h40, 5'd1);
    @(posedge clk);
    in_valid <= 1'b0;
    @(posedge clk);
    stall <= 1'b1;
    drive_instr(1'b1, op_jal, 3'd0, 7'd0, 32'h200, 32'd0, 32'd0, 32'h80, 5'd2);
    @(negedge clk);
    snap = {out_valid, out_result, out_store_data, out_rd, out_redirect, out_target};
    check_value("out_target", 32'h140, out_target);
    repeat (5) begin
        @(posedge clk);
        @(negedge clk);
        held = {out_valid, out_result, out_store_data, out_rd, out_redirect, out_target};
        check_count++;
        if (held !== snap) begin
            error_count++;
            $display("error outputs held by stall: expected %h, got %h", snap, held);
        end
    end
    @(posedge clk);
    stall    <= 1'b0;
    in_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("out_valid", 32'd0, {31'd0, out_valid});
    // Flushed JAL
    @(posedge clk);
    drive_instr(1'b1, op_jal, 3'd0, 7'd0, 32'h300, 32'd0, 32'd0, 32'h40, 5'd3);
    flush <= 1'b1;
    @(posedge clk);
    in_valid <= 1'b0;
    flush    <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("out_valid", 32'd0, {31'd0, out_valid});
    check_value("out_redirect", 32'd0, {31'd0, out_redirect});
    // JAL fields without in_valid
    @(posedge clk);
    drive_instr(1'b0, op_jal, 3'd0, 7'd0, 32'h400, 32'd0, 32'd0, 32'h40, 5'd4);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("out_redirect", 32'd0, {31'd0, out_redirect});
endtask

// File: dv/ex_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb;
    import ex_pkg::*;

    // About 250 instructions at 3 cycles each, with plenty of margin
    localparam int max_cycles = 3000;

    logic                  clk;
    logic                  reset;
    logic                  stall;
    logic                  flush;
    logic                  in_valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       data1;
    logic [xlen-1:0]       data2;
    logic [xlen-1:0]       imm;
    logic [opcode_w-1:0]   opcode;
    logic [funct3_w-1:0]   funct3;
    logic [funct7_w-1:0]   funct7;
    logic [reg_addr_w-1:0] rd;
    logic                  out_valid;
    logic                  out_redirect;
    logic [xlen-1:0]       out_result;
    logic [xlen-1:0]       out_store_data;
    logic [xlen-1:0]       out_target;
    logic [reg_addr_w-1:0] out_rd;

    // Expected values from the reference model
    logic [xlen-1:0]       exp_result;
    logic [xlen-1:0]       exp_target;
    logic                  exp_redirect;
    int                    error_count = 0;
    int                    check_count = 0;
    int                    cycle_count = 0;

    ex_stage ex_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // RV32I reference model for one instruction
    function automatic void predict(input logic [opcode_w-1:0] op,
                                    input logic [funct3_w-1:0] f3,
                                    input logic [funct7_w-1:0] f7, input logic [xlen-1:0] pc_v,
                                    input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                                    input logic [xlen-1:0] imm_v);
        logic [xlen-1:0] rhs;
        rhs          = (op == op_op) ? b : imm_v;
        exp_redirect = 1'b0;
        exp_target   = pc_v + imm_v;
        // Loads and stores compute an address
        exp_result   = a + imm_v;
        case (op)
            op_lui:   exp_result = imm_v;
            op_auipc: exp_result = pc_v + imm_v;
            op_jal, op_jalr: begin
                exp_result   = pc_v + 32'd4;
                exp_redirect = 1'b1;
                if (op == op_jalr) exp_target = (a + imm_v) & ~32'h1;
            end
            op_branch: begin
                case (f3)
                    3'd0:    exp_redirect = (a == b);
                    3'd1:    exp_redirect = (a != b);
                    3'd4:    exp_redirect = ($signed(a) < $signed(b));
                    3'd5:    exp_redirect = ($signed(a) >= $signed(b));
                    3'd6:    exp_redirect = (a < b);
                    default: exp_redirect = (a >= b);
                endcase
            end
            op_op, op_op_imm: begin
                case (f3)
                    3'd0:    exp_result = (op == op_op && f7[5]) ? a - rhs : a + rhs;
                    3'd1:    exp_result = a << rhs[4:0];
                    3'd2:    exp_result = {31'd0, $signed(a) < $signed(rhs)};
                    3'd3:    exp_result = {31'd0, a < rhs};
                    3'd4:    exp_result = a ^ rhs;
                    3'd5:    exp_result = f7[5] ? $unsigned($signed(a) >>> rhs[4:0])
                                                : a >> rhs[4:0];
                    3'd6:    exp_result = a | rhs;
                    default: exp_result = a & rhs;
                endcase
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic drive_instr(input logic v, input logic [opcode_w-1:0] op,
                               input logic [funct3_w-1:0] f3, input logic [funct7_w-1:0] f7,
                               input logic [xlen-1:0] pc_v, input logic [xlen-1:0] a,
                               input logic [xlen-1:0] b, input logic [xlen-1:0] imm_v,
                               input logic [reg_addr_w-1:0] rd_v);
        in_valid <= v;
        opcode   <= op;
        funct3   <= f3;
        funct7   <= f7;
        pc       <= pc_v;
        data1    <= a;
        data2    <= b;
        imm      <= imm_v;
        rd       <= rd_v;
    endtask

    // Issue one instruction, outputs settle two edges later
    task automatic exec_check(input logic [opcode_w-1:0] op, input logic [funct3_w-1:0] f3,
                              input logic [funct7_w-1:0] f7, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input logic [xlen-1:0] imm_v);
        logic [xlen-1:0]       pc_v;
        logic [reg_addr_w-1:0] rd_v;
        pc_v = $urandom() & 32'hffff_fffc;
        rd_v = 5'($urandom());
        predict(op, f3, f7, pc_v, a, b, imm_v);
        @(posedge clk);
        drive_instr(1'b1, op, f3, f7, pc_v, a, b, imm_v, rd_v);
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("out_valid", 32'd1, {31'd0, out_valid});
        check_value("out_redirect", {31'd0, exp_redirect}, {31'd0, out_redirect});
        check_value("out_rd", {27'd0, rd_v}, {27'd0, out_rd});
        check_value("out_store_data", b, out_store_data);
        // Branches write no register
        if (op != op_branch) begin
            check_value("out_result", exp_result, out_result);
        end
        if (exp_redirect) begin
            check_value("out_target", exp_target, out_target);
        end
    endtask

    `include "ex_stage_tests.svh"

    initial begin
        void'($urandom(6));
        reset = 1'b1;
        {stall, flush, in_valid} = '0;
        {pc, data1, data2, imm} = '0;
        {opcode, funct3, funct7, rd} = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        reset_clears_outputs();
        reg_reg_ops();
        imm_and_upper_ops();
        branch_conditions();
        jumps_loads_stores();
        stall_flush_valid();
        @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_stage.f
+incdir+dv
design/ex_pkg.sv
design/ex_if.sv
design/id_ex_reg.sv
design/ex_ctrl.sv
design/ex_alu.sv
design/branch_resolve.sv
design/ex_mem_reg.sv
design/ex_stage.sv
dv/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module ex_stage_tb -f ex_stage.f

out=$(./obj_dir/Vex_stage_tb) || true
echo "$out"
echo "$out" | grep -qxF '** PASS **'
